//--- design/alias_table.sv
`timescale 1ns/10ps

module alias_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rename_pkg::arch_reg_t lookup_rs1,
    input  rename_pkg::arch_reg_t lookup_rs2,
    output rename_pkg::phys_reg_t map_rs1,
    output rename_pkg::phys_reg_t map_rs2,
    input  logic                  rat_write,
    input  rename_pkg::arch_reg_t write_rd,
    input  rename_pkg::phys_reg_t write_phys,
    input  logic                  commit_valid,
    input  rename_pkg::arch_reg_t commit_rd,
    input  rename_pkg::phys_reg_t commit_phys,
    output logic                  release_valid,
    output rename_pkg::phys_reg_t release_phys,
    input  logic                  walk_en,
    input  rename_pkg::arch_reg_t walk_index,
    output rename_pkg::phys_reg_t walk_phys
);
    import rename_pkg::*;

    phys_reg_t spec_map [arch_regs];
    phys_reg_t arch_map [arch_regs];

    logic commit_real;

    // x0 commits leave both tables and the free list alone
    assign commit_real = commit_valid && (commit_rd != '0);

    // ====================
    // Table updates
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                spec_map[i] <= phys_reg_t'(i);
                arch_map[i] <= phys_reg_t'(i);
            end
        end else begin
            // Speculative side: rename write or one recovery step
            if (walk_en) begin
                spec_map[walk_index] <= arch_map[walk_index];
            end else if (rat_write) begin
                spec_map[write_rd] <= write_phys;
            end

            if (commit_real) begin
                arch_map[commit_rd] <= commit_phys;
            end
        end
    end

    // ====================
    // Read ports
    // ====================
    assign map_rs1 = spec_map[lookup_rs1];
    assign map_rs2 = spec_map[lookup_rs2];

    // Old architectural mapping goes back to the free list
    assign release_valid = commit_real;
    assign release_phys  = arch_map[commit_rd];

    assign walk_phys = arch_map[walk_index];

endmodule

//--- design/free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  alloc,
    output rename_pkg::phys_reg_t free_phys,
    output logic                  any_free,
    input  logic                  release_valid,
    input  rename_pkg::phys_reg_t release_phys,
    input  logic                  walk_en,
    input  rename_pkg::phys_reg_t walk_phys
);
    import rename_pkg::*;

    logic [phys_regs-1:0] busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Identity mapping holds the lower half
            busy <= {{(phys_regs - arch_regs){1'b0}}, {arch_regs{1'b1}}};
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (alloc) begin
                busy[free_phys] <= 1'b1;
            end
            if (release_valid) begin
                busy[release_phys] <= 1'b0;
            end
            // Rebuild from the architectural table
            if (walk_en) begin
                busy[walk_phys] <= 1'b1;
            end
        end
    end

    // Lowest free register wins
    always_comb begin
        free_phys = '0;
        for (int i = phys_regs - 1; i >= 0; i--) begin
            if (!busy[i]) free_phys = phys_reg_t'(i);
        end
    end

    assign any_free = ~&busy;

endmodule

//--- design/recovery_ctrl.sv
`timescale 1ns/10ps

module recovery_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic last_index,
    output logic walk_en,
    output logic renaming
);
    import rename_pkg::*;

    rec_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_run;
        end else begin
            case (state)
                st_run:     if (flush) state <= st_recover;
                st_recover: if (last_index) state <= st_run;
                default:    state <= st_run;
            endcase
        end
    end

    // A second flush mid-walk restarts the walk from index 0
    assign walk_en  = (state == st_recover) && !flush;
    assign renaming = (state == st_run) && !flush;

endmodule

//--- design/rename_pkg.sv
package rename_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int rob_depth = 16;
    localparam int xlen      = 32;

    // ====================
    // Register-number types
    // ====================
    typedef logic [4:0]      arch_reg_t;
    typedef logic [5:0]      phys_reg_t;
    typedef logic [3:0]      rob_id_t;
    typedef logic [xlen-1:0] pc_t;

    // Control states of the recovery FSM
    typedef enum logic {
        st_run     = 1'b0,
        st_recover = 1'b1
    } rec_state_t;

endpackage

//--- design/rename_stage.sv
`timescale 1ns/10ps

module rename_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    input  rename_pkg::pc_t       in_pc,
    input  rename_pkg::arch_reg_t in_rs1,
    input  rename_pkg::arch_reg_t in_rs2,
    input  rename_pkg::arch_reg_t in_rd,
    output logic                  in_ready,
    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::pc_t       out_pc,
    output rename_pkg::phys_reg_t out_phys_rs1,
    output rename_pkg::phys_reg_t out_phys_rs2,
    output rename_pkg::phys_reg_t out_phys_rd,
    output rename_pkg::rob_id_t   out_rob_id,
    input  logic                  renaming,
    input  rename_pkg::phys_reg_t map_rs1,
    input  rename_pkg::phys_reg_t map_rs2,
    input  rename_pkg::phys_reg_t free_phys,
    input  logic                  any_free,
    input  rename_pkg::rob_id_t   next_id,
    input  logic                  id_free,
    output rename_pkg::arch_reg_t lookup_rs1,
    output rename_pkg::arch_reg_t lookup_rs2,
    output logic                  alloc,
    output logic                  rat_write,
    output rename_pkg::arch_reg_t write_rd,
    output rename_pkg::phys_reg_t write_phys
);
    import rename_pkg::*;

    logic started;
    logic need_rd;
    logic slot_open;
    logic transfer;

    // ====================
    // Handshake and resources
    // ====================
    assign need_rd   = (in_rd != '0);
    assign slot_open = !out_valid || out_ready;
    assign in_ready  = started && renaming && slot_open && id_free && (!need_rd || any_free);
    assign transfer  = in_valid && in_ready;

    assign lookup_rs1 = in_rs1;
    assign lookup_rs2 = in_rs2;
    assign alloc      = transfer;
    assign rat_write  = transfer && need_rd;
    assign write_rd   = in_rd;
    assign write_phys = free_phys;

    // Holds off acceptance until the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) started <= 1'b0;
        else        started <= 1'b1;
    end

    // ====================
    // Output slot
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (transfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            out_pc       <= in_pc;
            out_phys_rs1 <= map_rs1;
            out_phys_rs2 <= map_rs2;
            out_phys_rd  <= need_rd ? free_phys : '0;
            out_rob_id   <= next_id;
        end
    end

endmodule

//--- design/rename_top.sv
`timescale 1ns/10ps

module rename_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  rename_pkg::pc_t       in_pc,
    input  rename_pkg::arch_reg_t in_rs1,
    input  rename_pkg::arch_reg_t in_rs2,
    input  rename_pkg::arch_reg_t in_rd,
    output logic                  in_ready,
    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::pc_t       out_pc,
    output rename_pkg::phys_reg_t out_phys_rs1,
    output rename_pkg::phys_reg_t out_phys_rs2,
    output rename_pkg::phys_reg_t out_phys_rd,
    output rename_pkg::rob_id_t   out_rob_id,
    input  logic                  commit_valid,
    input  rename_pkg::arch_reg_t commit_rd,
    input  rename_pkg::phys_reg_t commit_phys,
    input  logic                  flush
);
    import rename_pkg::*;

    logic      renaming;
    logic      walk_en;
    logic      last_index;
    arch_reg_t walk_index;
    phys_reg_t walk_phys;

    arch_reg_t lookup_rs1;
    arch_reg_t lookup_rs2;
    phys_reg_t map_rs1;
    phys_reg_t map_rs2;

    logic      alloc;
    logic      rat_write;
    arch_reg_t write_rd;
    phys_reg_t write_phys;

    logic      release_valid;
    phys_reg_t release_phys;
    phys_reg_t free_phys;
    logic      any_free;
    rob_id_t   next_id;
    logic      id_free;

    recovery_ctrl u_recovery_ctrl (.*);

    walk_counter u_walk_counter (.*);

    alias_table u_alias_table (.*);

    // The free list only allocates when the destination is a real register
    free_list u_free_list (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .alloc         (rat_write),
        .free_phys     (free_phys),
        .any_free      (any_free),
        .release_valid (release_valid),
        .release_phys  (release_phys),
        .walk_en       (walk_en),
        .walk_phys     (walk_phys)
    );

    rob_id_alloc u_rob_id_alloc (.*);

    rename_stage u_rename_stage (.*);

endmodule

//--- design/rob_id_alloc.sv
`timescale 1ns/10ps

module rob_id_alloc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                alloc,
    input  logic                commit_valid,
    output rename_pkg::rob_id_t next_id,
    output logic                id_free
);
    import rename_pkg::*;

    rob_id_t    head;
    rob_id_t    tail;
    logic [4:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Commits always retire the oldest id
            if (commit_valid) head <= head + rob_id_t'(1);

            if (flush) begin
                // Drop everything younger than the head
                tail  <= commit_valid ? head + rob_id_t'(1) : head;
                count <= '0;
            end else begin
                if (alloc) tail <= tail + rob_id_t'(1);
                if (alloc && !commit_valid) count <= count + 5'd1;
                else if (commit_valid && !alloc) count <= count - 5'd1;
            end
        end
    end

    assign next_id = tail;
    assign id_free = (count != 5'(rob_depth));

endmodule

//--- design/walk_counter.sv
`timescale 1ns/10ps

module walk_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  walk_en,
    output rename_pkg::arch_reg_t walk_index,
    output logic                  last_index
);
    import rename_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            walk_index <= '0;
        end else if (walk_en) begin
            walk_index <= walk_index + arch_reg_t'(1);
        end else begin
            walk_index <= '0;
        end
    end

    assign last_index = walk_en && (walk_index == arch_reg_t'(arch_regs - 1));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rename -f sources.f -o tb_rename > build.log 2>&1 \
    && ./obj_dir/tb_rename > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; cat sim.log; exit 1; }

//--- sim/rename_props.sv
`timescale 1ns/10ps

module rename_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input rename_pkg::pc_t       out_pc,
    input rename_pkg::phys_reg_t out_phys_rs1,
    input rename_pkg::phys_reg_t out_phys_rs2,
    input rename_pkg::phys_reg_t out_phys_rd,
    input rename_pkg::rob_id_t   out_rob_id,
    input logic                  commit_valid,
    input logic                  walk_en,
    input logic                  flush
);
    import rename_pkg::*;

    logic [5:0] block_cnt;

    // Cycles left in the blocked window after a flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_cnt <= '0;
        end else if (flush) begin
            block_cnt <= 6'd32;
        end else if (block_cnt != '0) begin
            block_cnt <= block_cnt - 6'd1;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> out_valid &&
        $stable({out_pc, out_phys_rs1, out_phys_rs2, out_phys_rd, out_rob_id}))
        else $error("Output slot changed under back-pressure");

    a_flush_block: assert property (@(posedge clk) disable iff (!rst_n)
        (flush || block_cnt != '0) |-> !in_ready)
        else $error("in_ready high within the recovery window");

    a_no_commit_walk: assert property (@(posedge clk) disable iff (!rst_n)
        !(commit_valid && walk_en))
        else $error("Commit during recovery walk");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !in_ready && !out_valid)
        else $error("Handshake active during reset");

endmodule

bind rename_top rename_props i_props (.*);

//--- sim/tb_rename.sv
`timescale 1ns/10ps

module tb_rename;
    import rename_pkg::*;

    localparam int timeout_cycles = 200;

    typedef struct packed {
        pc_t       pc;
        phys_reg_t rs1;
        phys_reg_t rs2;
        phys_reg_t rd;
        rob_id_t   rob;
    } exp_t;

    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t phys;
    } flight_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    pc_t       in_pc;
    arch_reg_t in_rs1;
    arch_reg_t in_rs2;
    arch_reg_t in_rd;
    logic      in_ready;
    logic      out_valid;
    logic      out_ready;
    pc_t       out_pc;
    phys_reg_t out_phys_rs1;
    phys_reg_t out_phys_rs2;
    phys_reg_t out_phys_rd;
    rob_id_t   out_rob_id;
    logic      commit_valid;
    arch_reg_t commit_rd;
    phys_reg_t commit_phys;
    logic      flush;

    int    seed;
    string test_name;
    logic  bp_on;
    logic  bp_bit;
    pc_t   pc_next;

    // Reference model
    phys_reg_t            spec_m [arch_regs];
    phys_reg_t            arch_m [arch_regs];
    logic [phys_regs-1:0] busy_m;
    rob_id_t              head_m;
    rob_id_t              tail_m;
    exp_t                 exp_q [$];
    flight_t              fly_q [$];

    rename_top i_dut (.*);

    always #4 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string field, input int expected, input int actual);
        if (expected != actual) begin
            stop_with_error($sformatf("Fail %s %s: expected %0d, actual %0d",
                                      test_name, field, expected, actual));
        end
    endtask

    function automatic arch_reg_t rand_reg();
        return arch_reg_t'(1 + ($unsigned($random(seed)) % 31));
    endfunction

    // Expected record for an instruction entering now
    function automatic exp_t predict(pc_t pc, arch_reg_t rs1, arch_reg_t rs2, arch_reg_t rd);
        exp_t e;
        e.pc  = pc;
        e.rs1 = spec_m[rs1];
        e.rs2 = spec_m[rs2];
        e.rd  = '0;
        e.rob = tail_m;
        if (rd != '0) begin
            for (int i = 0; i < phys_regs; i++) begin
                if (!busy_m[i]) begin
                    e.rd = phys_reg_t'(i);
                    break;
                end
            end
        end
        return e;
    endfunction

    // ====================
    // Stimulus tasks
    // ====================
    task automatic drive_input(input arch_reg_t rs1, input arch_reg_t rs2, input arch_reg_t rd);
        in_valid = 1'b1;
        in_pc    = pc_next;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_rd    = rd;
    endtask

    task automatic take_input();
        int      waited;
        exp_t    e;
        flight_t f;
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > timeout_cycles) stop_with_error("Input handshake never completed");
            @(negedge clk);
        end
        e = predict(in_pc, in_rs1, in_rs2, in_rd);
        exp_q.push_back(e);
        if (in_rd != '0) begin
            busy_m[e.rd]  = 1'b1;
            spec_m[in_rd] = e.rd;
        end
        tail_m = tail_m + rob_id_t'(1);
        f.rd   = in_rd;
        f.phys = e.rd;
        fly_q.push_back(f);
        pc_next = pc_next + 32'd4;
        @(posedge clk);
        #1 in_valid = 1'b0;
    endtask

    task automatic send(input arch_reg_t rs1, input arch_reg_t rs2, input arch_reg_t rd);
        drive_input(rs1, rs2, rd);
        take_input();
    endtask

    // Retires the oldest in-flight instruction
    task automatic commit_one();
        flight_t f;
        if (fly_q.size() == 0) stop_with_error("Commit requested with nothing in flight");
        f = fly_q.pop_front();
        commit_valid = 1'b1;
        commit_rd    = f.rd;
        commit_phys  = f.phys;
        @(negedge clk);
        if (f.rd != '0) begin
            busy_m[arch_m[f.rd]] = 1'b0;
            arch_m[f.rd]         = f.phys;
        end
        head_m = head_m + rob_id_t'(1);
        @(posedge clk);
        #1 commit_valid = 1'b0;
    endtask

    task automatic commit_all();
        int n;
        n = fly_q.size();
        repeat (n) commit_one();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (out_valid || exp_q.size() != 0) begin
            waited++;
            if (waited > timeout_cycles) stop_with_error("Output handshake never completed");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic flush_and_recover();
        flush = 1'b1;
        @(negedge clk);
        check("in_ready in flush cycle", 0, int'(in_ready));
        // Recovery restores everything from the committed state
        fly_q.delete();
        spec_m = arch_m;
        busy_m = '0;
        for (int i = 0; i < arch_regs; i++) busy_m[arch_m[i]] = 1'b1;
        tail_m = head_m;
        @(posedge clk);
        #1 flush = 1'b0;
        repeat (32) begin
            @(negedge clk);
            check("in_ready during recovery", 0, int'(in_ready));
        end
        @(negedge clk);
        check("in_ready after recovery", 1, int'(in_ready));
        @(posedge clk);
        #1;
    endtask

    // ====================
    // Compare process
    // ====================
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) stop_with_error("Output appeared with no matching input");
            e = exp_q.pop_front();
            check("pc", int'(e.pc), int'(out_pc));
            check("phys_rs1", int'(e.rs1), int'(out_phys_rs1));
            check("phys_rs2", int'(e.rs2), int'(out_phys_rs2));
            check("phys_rd", int'(e.rd), int'(out_phys_rd));
            check("rob_id", int'(e.rob), int'(out_rob_id));
        end
    end

    // Random back-pressure, drawn away from the stimulus edge
    always @(negedge clk) bp_bit = 1'($random(seed));

    always @(posedge clk) begin
        #1 out_ready = !bp_on || bp_bit;
    end

    initial begin
        arch_reg_t prev;
        arch_reg_t rd;
        seed         = 49;
        bp_on        = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_rd        = '0;
        out_ready    = 1'b1;
        commit_valid = 1'b0;
        commit_rd    = '0;
        commit_phys  = '0;
        flush        = 1'b0;
        pc_next      = 32'h0000_1000;
        busy_m       = '0;
        head_m       = '0;
        tail_m       = '0;
        for (int i = 0; i < arch_regs; i++) begin
            spec_m[i] = phys_reg_t'(i);
            arch_m[i] = phys_reg_t'(i);
            busy_m[i] = 1'b1;
        end
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // Dependent chain fills all 16 ROB ids
        test_name = "chain";
        prev = '0;
        for (int i = 0; i < rob_depth; i++) begin
            rd = rand_reg();
            send(prev, arch_reg_t'(i), rd);
            prev = rd;
        end

        test_name = "rob_full";
        drive_input(prev, '0, rand_reg());
        repeat (20) begin
            @(negedge clk);
            check("in_ready with ROB full", 0, int'(in_ready));
        end
        @(posedge clk);
        #1;
        commit_one();
        take_input();
        commit_all();

        // Mixed destinations including x0
        test_name = "commit_release";
        for (int i = 0; i < 12; i++) begin
            rd = (i % 3 == 0) ? arch_reg_t'(0) : rand_reg();
            send(arch_reg_t'($random(seed)), arch_reg_t'($random(seed)), rd);
            if (i == 5) repeat (4) commit_one();
        end
        commit_all();

        test_name = "flush";
        repeat (6) send(rand_reg(), rand_reg(), rand_reg());
        repeat (2) commit_one();
        wait_drain();
        flush_and_recover();
        for (int i = 0; i < arch_regs; i++) begin
            send(arch_reg_t'(i), rand_reg(), rand_reg());
            // Retire before the ROB runs out of ids
            if (fly_q.size() == rob_depth) commit_all();
        end
        commit_all();

        test_name = "backpressure";
        bp_on = 1'b1;
        repeat (3) begin
            repeat (12) send(arch_reg_t'($random(seed)), rand_reg(), arch_reg_t'($random(seed)));
            commit_all();
        end
        bp_on = 1'b0;
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- sources.f
design/rename_pkg.sv
design/recovery_ctrl.sv
design/walk_counter.sv
design/alias_table.sv
design/free_list.sv
design/rob_id_alloc.sv
design/rename_stage.sv
design/rename_top.sv
sim/rename_props.sv
sim/tb_rename.sv
